// File: alu_unit.sv
`include "ooo_macros.svh"

module alu_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue,
    input  ooo_pkg::dispatch_t op,
    output ooo_pkg::cdb_t      result
);
    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    logic [4:0]           shamt;
    logic [`OOO_XLEN-1:0] alu_out;

    assign a     = op.src1.value;
    assign b     = op.src2.value;
    assign shamt = b[4:0];

    always_comb begin
        case (op.op)
            OP_SUB:  alu_out = a - b;
            OP_SLL:  alu_out = a << shamt;
            OP_SLT:  alu_out = {31'd0, $signed(a) < $signed(b)};
            OP_SLTU: alu_out = {31'd0, a < b};
            OP_XOR:  alu_out = a ^ b;
            OP_SRL:  alu_out = a >> shamt;
            OP_SRA:  alu_out = $unsigned($signed(a) >>> shamt);
            OP_OR:   alu_out = a | b;
            OP_AND:  alu_out = a & b;
            default: alu_out = a + b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid <= issue;   // one cycle pulse
            result.tag   <= op.dst;
            result.value <= alu_out;
        end
    end

endmodule

// File: inst_decoder.sv
module inst_decoder (
    input  ooo_pkg::inst_u inst,
    output ooo_pkg::uop_t  uop
);
    import ooo_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

    logic is_imm;
    logic alt;   // funct7 bit 5, sub / sra

    assign is_imm = (inst.r.opcode == OPC_OP_IMM);
    assign alt    = inst.r.funct7[5];

    always_comb begin
        uop         = '0;
        uop.use_imm = is_imm;
        uop.imm     = {{20{inst.i.imm12[11]}}, inst.i.imm12};
        uop.rs1     = inst.i.rs1;
        uop.rs2     = inst.r.rs2;
        uop.rd      = inst.r.rd;
        uop.is_mul  = !is_imm && (inst.r.funct7 == FUNCT7_MUL);

        case (inst.r.funct3)
            3'b000: begin
                // only the register add has a sub form
                if (!is_imm && !uop.is_mul && alt) begin
                    uop.op = OP_SUB;
                end else begin
                    uop.op = OP_ADD;
                end
            end
            3'b001: uop.op = OP_SLL;
            3'b010: uop.op = OP_SLT;
            3'b011: uop.op = OP_SLTU;
            3'b100: uop.op = OP_XOR;
            3'b101: uop.op = alt ? OP_SRA : OP_SRL;  // srai keeps funct7 in imm
            3'b110: uop.op = OP_OR;
            default: uop.op = OP_AND;
        endcase
    end

endmodule

// File: multiplier.sv
`include "ooo_macros.svh"

module multiplier (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue,
    input  ooo_pkg::dispatch_t op,
    output logic               busy,
    output ooo_pkg::cdb_t      result
);
    import ooo_pkg::*;

    localparam int STEPS = `OOO_XLEN / `OOO_MUL_STEP;
    localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic [`OOO_XLEN-1:0] mcand;
    logic [`OOO_XLEN-1:0] mplier;
    logic [`OOO_XLEN-1:0] acc;
    logic [CNT_W-1:0]     cnt;
    tag_t                 dst;
    logic [`OOO_XLEN-1:0] step_a;
    logic [`OOO_XLEN-1:0] step_b;
    logic [`OOO_XLEN-1:0] step_sum;
    logic                 last;

    // first step runs in the issue cycle straight from the operands
    always_comb begin
        step_a   = issue ? op.src1.value : mcand;
        step_b   = issue ? op.src2.value : mplier;
        step_sum = issue ? '0 : acc;
        for (int k = 0; k < `OOO_MUL_STEP; k++) begin
            if (step_b[k]) begin
                step_sum = step_sum + (step_a << k);
            end
        end
    end

    assign last = busy && (cnt == CNT_W'(STEPS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            result <= '0;
        end else begin
            result.valid <= last;
            if (last) begin
                result.tag   <= dst;
                result.value <= step_sum;   // low word only
            end
            if (issue) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue || busy) begin
            acc    <= step_sum;
            mcand  <= step_a << `OOO_MUL_STEP;
            mplier <= step_b >> `OOO_MUL_STEP;
        end
        if (issue) begin
            dst <= op.dst;
        end
    end

endmodule

// File: ooo_core.f
+incdir+.
ooo_pkg.sv
inst_decoder.sv
register_alias_table.sv
reservation_station.sv
alu_unit.sv
multiplier.sv
reorder_buffer.sv
ooo_core.sv
ooo_core_properties.sv
ooo_core_tb.sv

// File: ooo_core.sv
module ooo_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    output logic             stall,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    uop_t        uop;
    logic        rs1_busy, rs2_busy;
    tag_t        rs1_tag, rs2_tag;
    logic [31:0] rs1_value, rs2_value;
    logic        lk1_done, lk2_done;
    logic [31:0] lk1_value, lk2_value;
    tag_t        tail, head;
    logic        rob_full, alu_full, mul_full;
    logic        accept, alu_write, mul_write;
    dispatch_t   entry;
    logic        alu_issue, mul_issue, mul_busy;
    dispatch_t   alu_op, mul_op;
    cdb_t        alu_cdb, mul_cdb;

    // register file, then ROB, then a result on the bus this cycle
    function automatic operand_t source_operand(logic busy, tag_t tag, logic [31:0] reg_value,
                                                logic rob_done, logic [31:0] rob_value);
        operand_t o;
        o.ready = !busy || rob_done;
        o.tag   = tag;
        o.value = busy ? rob_value : reg_value;
        return snoop_operand(o, alu_cdb, mul_cdb);
    endfunction

    always_comb begin
        entry.op   = uop.op;
        entry.src1 = source_operand(rs1_busy, rs1_tag, rs1_value, lk1_done, lk1_value);
        entry.src2 = source_operand(rs2_busy, rs2_tag, rs2_value, lk2_done, lk2_value);
        entry.dst  = tail;
        if (uop.use_imm) begin
            entry.src2 = '{ready: 1'b1, tag: '0, value: uop.imm};
        end
    end

    assign stall     = rob_full || (uop.is_mul ? mul_full : alu_full);
    assign accept    = inst_valid && !stall;
    assign alu_write = accept && !uop.is_mul;
    assign mul_write = accept && uop.is_mul;

    inst_decoder dec_i (.inst(inst), .uop(uop));

    register_alias_table rat_i (
        .clk(clk), .rst_n(rst_n),
        .rs1(uop.rs1), .rs2(uop.rs2),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .rename(accept), .rd(uop.rd), .rd_tag(tail),
        .retire(commit), .retire_tag(head)
    );

    reservation_station alu_rs (
        .clk(clk), .rst_n(rst_n), .write(alu_write), .entry(entry), .full(alu_full),
        .unit_busy(1'b0), .alu_cdb(alu_cdb), .mul_cdb(mul_cdb),
        .issue(alu_issue), .issued(alu_op)
    );

    reservation_station mul_rs (
        .clk(clk), .rst_n(rst_n), .write(mul_write), .entry(entry), .full(mul_full),
        .unit_busy(mul_busy), .alu_cdb(alu_cdb), .mul_cdb(mul_cdb),
        .issue(mul_issue), .issued(mul_op)
    );

    alu_unit alu_i (
        .clk(clk), .rst_n(rst_n), .issue(alu_issue), .op(alu_op), .result(alu_cdb)
    );

    multiplier mul_i (
        .clk(clk), .rst_n(rst_n), .issue(mul_issue), .op(mul_op),
        .busy(mul_busy), .result(mul_cdb)
    );

    reorder_buffer rob_i (
        .clk(clk), .rst_n(rst_n),
        .alloc(accept), .tail(tail), .full(rob_full), .alloc_rd(uop.rd),
        .lookup1_tag(rs1_tag), .lookup2_tag(rs2_tag),
        .lookup1_done(lk1_done), .lookup2_done(lk2_done),
        .lookup1_value(lk1_value), .lookup2_value(lk2_value),
        .alu_cdb(alu_cdb), .mul_cdb(mul_cdb),
        .commit(commit), .head(head)
    );

endmodule

// File: ooo_core_input.txt
// columns: instruction word (hex), expected committed value (hex)
// the committed rd is bits 11:7 of the word
00500093 00000005  // addi x1, x0, 5
FFD00113 FFFFFFFD  // addi x2, x0, -3
002081B3 00000002  // add  x3, x1, x2
40208233 00000008  // sub  x4, x1, x2
0F00C293 000000F5  // xori x5, x1, 0xf0
7F017313 000007F0  // andi x6, x2, 0x7f0
001123B3 00000001  // slt  x7, x2, x1
00113433 00000000  // sltu x8, x2, x1
00409493 00000050  // slli x9, x1, 4
40115513 FFFFFFFE  // srai x10, x2, 1
01C15593 0000000F  // srli x11, x2, 28
0092E633 000000F5  // or   x12, x5, x9
005376B3 000000F0  // and  x13, x6, x5
00100713 00000001  // addi x14, x0, 1
00E70733 00000002  // add  x14, x14, x14
00E70733 00000004  // add  x14, x14, x14
00371713 00000020  // slli x14, x14, 3
40170733 0000001B  // sub  x14, x14, x1
00C747B3 000000EE  // xor  x15, x14, x12
02208833 FFFFFFF1  // mul  x16, x1, x2
06400893 00000064  // addi x17, x0, 100
00188933 00000069  // add  x18, x17, x1
030809B3 000000E1  // mul  x19, x16, x16
00B09A33 00028000  // sll  x20, x1, x11
00708013 0000000C  // addi x0, x1, 7
00100AB3 00000005  // add  x21, x0, x1
02108033 00000019  // mul  x0, x1, x1
00006B33 00000000  // or   x22, x0, x0
02108BB3 00000019  // mul  x23, x1, x1
021B8C33 0000007D  // mul  x24, x23, x1
022C0CB3 FFFFFE89  // mul  x25, x24, x2
02210D33 00000009  // mul  x26, x2, x2
039C8DB3 00022551  // mul  x27, x25, x25
03188E33 00002710  // mul  x28, x17, x17
022D0EB3 FFFFFFE5  // mul  x29, x26, x2
03CD8F33 53D1AC10  // mul  x30, x27, x28
030E8FB3 00000195  // mul  x31, x29, x16
01EF80B3 53D1ADA5  // add  x1, x31, x30

// File: ooo_core_properties.sv
module ooo_core_properties (
    input logic             clk,
    input logic             rst_n,
    input ooo_pkg::cdb_t    alu_cdb,
    input ooo_pkg::cdb_t    mul_cdb,
    input ooo_pkg::commit_t commit,
    input ooo_pkg::tag_t    head,
    input ooo_pkg::tag_t    tail,
    input logic             rob_full
);
    import ooo_pkg::*;

    logic rob_empty;

    assign rob_empty = (head == tail) && !rob_full;

    no_commit_in_reset: assert property (@(posedge clk) !rst_n |-> !commit.valid)
        else $error("commit valid while reset is asserted");

    // each tag has one producer in flight
    distinct_bus_tags: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_cdb.valid && mul_cdb.valid && alu_cdb.tag == mul_cdb.tag))
        else $error("both result buses carry tag %0d", alu_cdb.tag);

    no_commit_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        commit.valid |-> !rob_empty)
        else $error("commit from an empty reorder buffer");

endmodule

bind ooo_core ooo_core_properties props_i (
    .clk(clk),
    .rst_n(rst_n),
    .alu_cdb(alu_cdb),
    .mul_cdb(mul_cdb),
    .commit(commit),
    .head(head),
    .tail(tail),
    .rob_full(rob_full)
);

// File: ooo_core_tb.sv
`include "ooo_macros.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int STALL_LIMIT  = 200;    // cycles one instruction may be held
    localparam int COMMIT_LIMIT = 2000;   // cycles to drain after the last send

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    commit_t     commit;

    logic [31:0] inst_q [$];
    logic [31:0] exp_q [$];
    int          seed = 48754;
    int          sent_count = 0;
    int          commit_count = 0;
    int          mismatch_count = 0;
    int          other_errors = 0;

    ooo_core dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .inst_valid(inst_valid),
        .inst(inst),
        .stall(stall),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reads the hex word and expected value of each line
    task automatic load_program();
        int          fd;
        int          code;
        string       line;
        logic [31:0] word;
        logic [31:0] value;
        fd = $fopen("ooo_core_input.txt", "r");
        if (fd == 0) begin
            $display("could not open ooo_core_input.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                if ($sscanf(line, "%h %h", word, value) == 2) begin
                    inst_q.push_back(word);
                    exp_q.push_back(value);
                end
            end
        end
        $fclose(fd);
    endtask

    // hold the word until the core takes it
    task automatic send_inst(input logic [31:0] word, input int idx, output logic ok);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst       = word;
        @(negedge clk);
        while (stall && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = !stall;
        if (!ok) begin
            $display("stall stayed high for %0d cycles on instruction %0d", waited, idx);
            other_errors++;
        end
        @(posedge clk);   // taken here when stall is low
        if (ok) begin
            sent_count++;
        end
        #1;
        inst_valid = 1'b0;
        inst       = '0;
    endtask

    always @(negedge clk) begin
        logic [31:0] word;
        logic [4:0]  exp_rd;
        int          in_flight;
        if (rst_n) begin
            // a full reorder buffer must hold off the next word
            in_flight = sent_count - commit_count;
            if (in_flight >= `OOO_ROB_DEPTH && !stall) begin
                $display("Mismatch at time %0t: stall low with %0d entries in flight",
                         $time, in_flight);
                mismatch_count++;
            end
        end
        if (rst_n && commit.valid) begin
            if (commit_count >= inst_q.size()) begin
                $display("extra commit at time %0t with rd %0d value %h",
                         $time, commit.rd, commit.value);
                other_errors++;
            end else begin
                word   = inst_q[commit_count];
                exp_rd = word[11:7];
                if (commit.rd != exp_rd || commit.value != exp_q[commit_count]) begin
                    $display("Mismatch at time %0t: commit %0d rd %0d/%h, expected %0d/%h",
                             $time, commit_count, commit.rd, commit.value,
                             exp_rd, exp_q[commit_count]);
                    mismatch_count++;
                end
            end
            commit_count++;
        end
    end

    initial begin
        logic ok;
        int   gap;
        int   waited;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        load_program();
        if (inst_q.size() == 0) begin
            $display("no instructions were read from the input file");
            other_errors++;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        ok = 1'b1;
        for (int i = 0; i < inst_q.size() && ok; i++) begin
            gap = $unsigned($random(seed)) % 4;   // idle cycles before the next word
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_inst(inst_q[i], i, ok);
        end

        waited = 0;
        while (commit_count < inst_q.size() && waited < COMMIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (commit_count < inst_q.size()) begin
            $display("timed out waiting for commits, saw %0d of %0d",
                     commit_count, inst_q.size());
            other_errors++;
        end
        repeat (20) @(posedge clk);   // window for duplicate commits

        $display("errors: %0d mismatches, %0d other, %0d commits of %0d",
                 mismatch_count, other_errors, commit_count, inst_q.size());
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// data path width
`define OOO_XLEN 32

// architectural registers x0..x31
`define OOO_NUM_AREGS 32

// reorder buffer entries, also the number of rename tags
`define OOO_ROB_DEPTH 8

// default reservation station depth
`define OOO_RS_DEPTH 4

// multiplier bits consumed per cycle
`define OOO_MUL_STEP 8

`endif

// File: ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // one word read through two field layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } alu_op_e;

    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] tag_t;

    typedef struct packed {
        alu_op_e              op;
        logic                 is_mul;
        logic                 use_imm;
        logic [`OOO_XLEN-1:0] imm;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
    } uop_t;

    typedef struct packed {
        logic                 ready;
        tag_t                 tag;   // valid while not ready
        logic [`OOO_XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        operand_t src1;
        operand_t src2;
        tag_t     dst;
    } dispatch_t;

    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic                 valid;
        logic [4:0]           rd;
        logic [`OOO_XLEN-1:0] value;
    } commit_t;

    // pick up a waited-on value from either result bus
    function automatic operand_t snoop_operand(operand_t op, cdb_t a, cdb_t b);
        operand_t res;
        res = op;
        if (!op.ready && a.valid && a.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = a.value;
        end else if (!op.ready && b.valid && b.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = b.value;
        end
        return res;
    endfunction

endpackage

// File: register_alias_table.sv
`include "ooo_macros.svh"

module register_alias_table (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic                rs1_busy,
    output logic                rs2_busy,
    output ooo_pkg::tag_t       rs1_tag,
    output ooo_pkg::tag_t       rs2_tag,
    output logic [31:0]         rs1_value,
    output logic [31:0]         rs2_value,
    input  logic                rename,
    input  logic [4:0]          rd,
    input  ooo_pkg::tag_t       rd_tag,
    input  ooo_pkg::commit_t    retire,
    input  ooo_pkg::tag_t       retire_tag
);
    import ooo_pkg::*;

    logic [`OOO_NUM_AREGS-1:0] busy;
    tag_t                      tag_map [`OOO_NUM_AREGS];
    logic [`OOO_XLEN-1:0]      regs [`OOO_NUM_AREGS];

    // x0 is never marked busy and never written, so reads zero
    assign rs1_busy  = busy[rs1];
    assign rs2_busy  = busy[rs2];
    assign rs1_tag   = tag_map[rs1];
    assign rs2_tag   = tag_map[rs2];
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (retire.valid && busy[retire.rd] && tag_map[retire.rd] == retire_tag) begin
                busy[retire.rd] <= 1'b0;
            end
            if (rename && rd != 5'd0) begin
                busy[rd] <= 1'b1;   // later write wins over the clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename && rd != 5'd0) begin
            tag_map[rd] <= rd_tag;
        end
    end

    // architectural state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_AREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != 5'd0) begin
            regs[retire.rd] <= retire.value;
        end
    end

endmodule

// File: reorder_buffer.sv
`include "ooo_macros.svh"

module reorder_buffer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alloc,
    output ooo_pkg::tag_t    tail,
    output logic             full,
    input  logic [4:0]       alloc_rd,
    input  ooo_pkg::tag_t    lookup1_tag,
    input  ooo_pkg::tag_t    lookup2_tag,
    output logic             lookup1_done,
    output logic             lookup2_done,
    output logic [31:0]      lookup1_value,
    output logic [31:0]      lookup2_value,
    input  ooo_pkg::cdb_t    alu_cdb,
    input  ooo_pkg::cdb_t    mul_cdb,
    output ooo_pkg::commit_t commit,
    output ooo_pkg::tag_t    head
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0]     done;
    logic [4:0]           rd_q [DEPTH];
    logic [`OOO_XLEN-1:0] value_q [DEPTH];
    logic [CNT_W-1:0]     count;
    tag_t                 sel;

    // head stays on the committing entry until its commit cycle ends,
    // so lookups by that tag still hit while the register file catches up
    assign sel  = commit.valid ? tag_t'(head + 1'b1) : head;
    assign full = (count == CNT_W'(DEPTH));

    assign lookup1_done  = done[lookup1_tag];
    assign lookup2_done  = done[lookup2_tag];
    assign lookup1_value = value_q[lookup1_tag];
    assign lookup2_value = value_q[lookup2_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done   <= '0;
            commit <= '0;
        end else begin
            commit.valid <= done[sel];
            commit.rd    <= rd_q[sel];
            commit.value <= value_q[sel];
            if (commit.valid) begin
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (alu_cdb.valid) begin
                done[alu_cdb.tag] <= 1'b1;
            end
            if (mul_cdb.valid) begin
                done[mul_cdb.tag] <= 1'b1;
            end
            case ({alloc, commit.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (alu_cdb.valid) begin
            value_q[alu_cdb.tag] <= alu_cdb.value;
        end
        if (mul_cdb.valid) begin
            value_q[mul_cdb.tag] <= mul_cdb.value;
        end
    end

endmodule

// File: reservation_station.sv
`include "ooo_macros.svh"

module reservation_station #(
    parameter int DEPTH = `OOO_RS_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               write,
    input  ooo_pkg::dispatch_t entry,
    output logic               full,
    input  logic               unit_busy,
    input  ooo_pkg::cdb_t      alu_cdb,
    input  ooo_pkg::cdb_t      mul_cdb,
    output logic               issue,
    output ooo_pkg::dispatch_t issued
);
    import ooo_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dispatch_t        slot [DEPTH];
    logic [DEPTH-1:0] used;
    logic [IDX_W-1:0] age [DEPTH];   // 0 is the oldest
    logic [IDX_W:0]   occupancy;
    logic [IDX_W-1:0] sel;
    logic [IDX_W-1:0] free_idx;
    logic             found;

    always_comb begin
        found     = 1'b0;
        sel       = '0;
        free_idx  = '0;
        occupancy = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (used[i]) begin
                occupancy = occupancy + 1'b1;
            end
            if (used[i] && slot[i].src1.ready && slot[i].src2.ready &&
                (!found || age[i] < age[sel])) begin
                found = 1'b1;
                sel   = IDX_W'(i);
            end
        end
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign full   = &used;
    assign issue  = found && !unit_busy;
    assign issued = slot[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            // close the gap left by the issued entry
            for (int i = 0; i < DEPTH; i++) begin
                if (issue && used[i] && age[i] > age[sel]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (issue) begin
                used[sel] <= 1'b0;
            end
            if (write) begin
                used[free_idx] <= 1'b1;
                age[free_idx]  <= IDX_W'(occupancy - (issue ? 1'b1 : 1'b0));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (used[i]) begin
                slot[i].src1 <= snoop_operand(slot[i].src1, alu_cdb, mul_cdb);
                slot[i].src2 <= snoop_operand(slot[i].src2, alu_cdb, mul_cdb);
            end
        end
        if (write) begin
            slot[free_idx] <= entry;
        end
    end

endmodule
